//--- flist.f
hw/xif_pkg.sv
hw/xif_issue_stage.sv
hw/copro_decode_stage.sv
hw/copro_execute_stage.sv
hw/xif_writeback_stage.sv
hw/xif_subsystem.sv
sim/xif_properties.sv
sim/xif_checker.sv
sim/xif_subsystem_tb.sv

//--- hw/copro_decode_stage.sv
`timescale 1ns/10ps

module copro_decode_stage
  import xif_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,

  input  logic         issue_valid_i,
  input  x_issue_req_t issue_req_i,

  output logic         dec_valid_o,
  output x_decoded_t   dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;

  logic       accept;
  copro_op_e  op;

  // R-type fields
  assign opcode = issue_req_i.instr[6:0];
  assign rd     = issue_req_i.instr[11:7];
  assign funct3 = issue_req_i.instr[14:12];
  assign funct7 = issue_req_i.instr[31:25];

  always_comb begin
    accept = 1'b0;
    op     = OP_NONE;
    if (opcode == CUSTOM0_OPCODE && funct7 == 7'b0 && funct3 != 3'd7) begin
      accept = 1'b1;
      // funct3 maps directly onto the enum
      op     = copro_op_e'(funct3);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      dec_o.id     <= issue_req_i.id;
      dec_o.rd     <= rd;
      dec_o.op     <= op;
      dec_o.rs1    <= issue_req_i.rs1;
      dec_o.rs2    <= issue_req_i.rs2;
      dec_o.accept <= accept;
    end
  end

endmodule : copro_decode_stage

//--- hw/copro_execute_stage.sv
`timescale 1ns/10ps

module copro_execute_stage
  import xif_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  logic       dec_valid_i,
  input  x_decoded_t dec_i,

  output logic       exec_valid_o,
  output x_exec_t    exec_o
);

  logic [XLEN-1:0] acc_q;
  logic [XLEN:0]   sum_ext;
  logic [XLEN-1:0] sat_sum;
  logic [XLEN-1:0] mac_sum;
  logic [XLEN-1:0] result;
  logic            acc_upd;
  logic [XLEN-1:0] acc_nxt;

  function automatic logic [XLEN-1:0] count_ones(input logic [XLEN-1:0] v);
    logic [5:0] n;
    n = '0;
    for (int i = 0; i < XLEN; i++) begin
      n = n + {5'b0, v[i]};
    end
    return {{(XLEN-6){1'b0}}, n};
  endfunction

  // Highest set bit wins, zero input gives XLEN
  function automatic logic [XLEN-1:0] count_lz(input logic [XLEN-1:0] v);
    logic [5:0] n;
    n = 6'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (v[i]) begin
        n = 6'(XLEN - 1 - i);
      end
    end
    return {{(XLEN-6){1'b0}}, n};
  endfunction

  // Sign-extended add, overflow when the top two bits differ
  assign sum_ext = {dec_i.rs1[XLEN-1], dec_i.rs1} + {dec_i.rs2[XLEN-1], dec_i.rs2};
  assign sat_sum = (sum_ext[XLEN] == sum_ext[XLEN-1]) ? sum_ext[XLEN-1:0] :
                   sum_ext[XLEN] ? {1'b1, {(XLEN-1){1'b0}}} : {1'b0, {(XLEN-1){1'b1}}};

  assign mac_sum = acc_q + dec_i.rs1 * dec_i.rs2;

  always_comb begin
    result  = '0;
    acc_nxt = acc_q;
    acc_upd = 1'b0;
    if (dec_i.accept) begin
      unique case (dec_i.op)
        OP_ADDSAT: result = sat_sum;
        OP_MIN:    result = ($signed(dec_i.rs1) < $signed(dec_i.rs2)) ? dec_i.rs1 : dec_i.rs2;
        OP_MAX:    result = ($signed(dec_i.rs1) > $signed(dec_i.rs2)) ? dec_i.rs1 : dec_i.rs2;
        OP_POPCNT: result = count_ones(dec_i.rs1);
        OP_CLZ:    result = count_lz(dec_i.rs1);
        OP_MAC: begin
          result  = mac_sum;
          acc_nxt = mac_sum;
          acc_upd = 1'b1;
        end
        OP_ACCCLR: begin
          result  = acc_q;
          acc_nxt = '0;
          acc_upd = 1'b1;
        end
        default:   result = '0;
      endcase
    end
  end

  // Updated on the edge the word leaves, so the next word sees it
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
    end else if (dec_valid_i && acc_upd) begin
      acc_q <= acc_nxt;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exec_valid_o <= 1'b0;
    end else begin
      exec_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      exec_o.id     <= dec_i.id;
      exec_o.rd     <= dec_i.rd;
      exec_o.data   <= result;
      exec_o.accept <= dec_i.accept;
    end
  end

endmodule : copro_execute_stage

//--- hw/xif_issue_stage.sv
`timescale 1ns/10ps

module xif_issue_stage
  import xif_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,

  input  logic            instr_valid_i,
  input  logic [31:0]     instr_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,

  output logic            issue_valid_o,
  output x_issue_req_t    issue_req_o
);

  logic [ID_W-1:0] id_cnt_q;

  // Rolling tag, wraps naturally at 16
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_cnt_q <= '0;
    end else if (instr_valid_i) begin
      id_cnt_q <= id_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= instr_valid_i;
    end
  end

  // Payload captured only on a strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      issue_req_o.instr <= instr_i;
      issue_req_o.rs1   <= rs1_i;
      issue_req_o.rs2   <= rs2_i;
      issue_req_o.id    <= id_cnt_q;
    end
  end

endmodule : xif_issue_stage

//--- hw/xif_pkg.sv
package xif_pkg;

  // Datapath and tag widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned ID_W = 4;

  // Major opcode claimed by the coprocessor
  localparam logic [6:0] CUSTOM0_OPCODE = 7'b0001011;

  // Illegal instruction exception code
  localparam logic [5:0] EXC_ILLEGAL = 6'd2;

  // Custom-0 operations, values follow funct3
  typedef enum logic [2:0] {
    OP_ADDSAT = 3'd0,
    OP_MIN    = 3'd1,
    OP_MAX    = 3'd2,
    OP_POPCNT = 3'd3,
    OP_CLZ    = 3'd4,
    OP_MAC    = 3'd5,
    OP_ACCCLR = 3'd6,
    OP_NONE   = 3'd7
  } copro_op_e;

  // Issue request, core to coprocessor
  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [ID_W-1:0] id;
  } x_issue_req_t;

  // Decoded word
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [4:0]      rd;
    copro_op_e       op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            accept;
  } x_decoded_t;

  // Execute outcome
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            accept;
  } x_exec_t;

  // Result record back to the core
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            we;
    logic            exc;
    logic [5:0]      exccode;
  } x_result_t;

endpackage : xif_pkg

//--- hw/xif_subsystem.sv
`timescale 1ns/10ps

module xif_subsystem
  import xif_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,

  input  logic            instr_valid_i,
  input  logic [31:0]     instr_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,

  output logic            result_valid_o,
  output x_result_t       result_o
);

  // Issue to decode
  logic         issue_valid;
  x_issue_req_t issue_req;

  // Decode to execute
  logic         dec_valid;
  x_decoded_t   dec;

  // Execute to writeback
  logic         exec_valid;
  x_exec_t      exec;

  xif_issue_stage issue_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .issue_valid_o(issue_valid),
    .issue_req_o  (issue_req)
  );

  copro_decode_stage decode_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .issue_valid_i(issue_valid),
    .issue_req_i  (issue_req),
    .dec_valid_o  (dec_valid),
    .dec_o        (dec)
  );

  copro_execute_stage execute_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .exec_valid_o(exec_valid),
    .exec_o      (exec)
  );

  xif_writeback_stage writeback_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .exec_valid_i  (exec_valid),
    .exec_i        (exec),
    .result_valid_o(result_valid_o),
    .result_o      (result_o)
  );

endmodule : xif_subsystem

//--- hw/xif_writeback_stage.sv
`timescale 1ns/10ps

module xif_writeback_stage
  import xif_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  logic      exec_valid_i,
  input  x_exec_t   exec_i,

  output logic      result_valid_o,
  output x_result_t result_o
);

  x_result_t rec;

  always_comb begin
    rec.id = exec_i.id;
    rec.rd = exec_i.rd;
    if (exec_i.accept) begin
      rec.data    = exec_i.data;
      // No architectural write to x0
      rec.we      = (exec_i.rd != 5'd0);
      rec.exc     = 1'b0;
      rec.exccode = '0;
    end else begin
      rec.data    = '0;
      rec.we      = 1'b0;
      rec.exc     = 1'b1;
      rec.exccode = EXC_ILLEGAL;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= exec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec_valid_i) begin
      result_o <= rec;
    end
  end

endmodule : xif_writeback_stage

//--- run.sh
#!/usr/bin/env bash
# Build the XIF subsystem testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module xif_subsystem_tb -f flist.f -o xif_sim \
  && ./obj_dir/xif_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/xif_checker.sv
`timescale 1ns/10ps

module xif_checker
  import xif_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] rs1_i,
  input  logic [31:0] rs2_i,
  input  logic        result_valid_i,
  input  x_result_t   result_i,
  input  logic        run_done_i,
  output int          pass_cnt_o,
  output int          err_cnt_o,
  output int          pending_o
);

  x_result_t       exp_q[$];
  logic [ID_W-1:0] ref_id        = '0;
  logic [31:0]     ref_acc       = '0;
  int              pass_cnt      = 0;
  int              err_cnt       = 0;
  int              pending       = 0;
  bit              leftover_done = 1'b0;

  assign pass_cnt_o = pass_cnt;
  assign err_cnt_o  = err_cnt;
  assign pending_o  = pending;

  function automatic logic [31:0] add_saturate(input logic [31:0] a, input logic [31:0] b);
    longint s;
    s = longint'($signed(a)) + longint'($signed(b));
    if (s > 64'sd2147483647) begin
      return 32'h7fff_ffff;
    end
    if (s < -64'sd2147483648) begin
      return 32'h8000_0000;
    end
    return 32'(s);
  endfunction

  function automatic logic [31:0] leading_zeros(input logic [31:0] v);
    int n;
    n = 0;
    for (int i = 31; i >= 0; i--) begin
      if (v[i]) begin
        break;
      end
      n++;
    end
    return 32'(n);
  endfunction

  // Expected record for one issued word, advancing tag and accumulator
  function automatic x_result_t predict(input logic [31:0] instr, input logic [31:0] a,
                                        input logic [31:0] b);
    x_result_t r;
    r      = '0;
    r.id   = ref_id;
    r.rd   = instr[11:7];
    ref_id = ref_id + 4'd1;
    if (instr[6:0] != CUSTOM0_OPCODE || instr[31:25] != 7'd0 || instr[14:12] == 3'd7) begin
      r.exc     = 1'b1;
      r.exccode = EXC_ILLEGAL;
      return r;
    end
    case (copro_op_e'(instr[14:12]))
      OP_ADDSAT: r.data = add_saturate(a, b);
      OP_MIN:    r.data = ($signed(a) < $signed(b)) ? a : b;
      OP_MAX:    r.data = ($signed(a) > $signed(b)) ? a : b;
      OP_POPCNT: r.data = 32'($countones(a));
      OP_CLZ:    r.data = leading_zeros(a);
      OP_MAC: begin
        ref_acc = ref_acc + a * b;
        r.data  = ref_acc;
      end
      default: begin
        r.data  = ref_acc;
        ref_acc = '0;
      end
    endcase
    r.we = (r.rd != 5'd0);
    return r;
  endfunction

  function automatic string format_record(input x_result_t r);
    return $sformatf("id %0d rd %0d data %h we %b exc %b code %0d",
                     r.id, r.rd, r.data, r.we, r.exc, r.exccode);
  endfunction

  always @(posedge clk_i) begin
    x_result_t want;
    if (arst_n_i) begin
      if (result_valid_i) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0d ns: result with id %0d arrived with no word outstanding",
                   $time, result_i.id);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          if (result_i !== want) begin
            $display("Fail at %0d ns: expected [%s] got [%s]", $time,
                     format_record(want), format_record(result_i));
            err_cnt++;
          end else begin
            pass_cnt++;
          end
        end
      end
      if (instr_valid_i) begin
        exp_q.push_back(predict(instr_i, rs1_i, rs2_i));
      end
      if (run_done_i && !leftover_done) begin
        leftover_done = 1'b1;
        if (exp_q.size() != 0) begin
          $display("Error: %0d issued words never produced a result", exp_q.size());
          err_cnt++;
        end
      end
      pending = exp_q.size();
    end
  end

endmodule : xif_checker

//--- sim/xif_properties.sv
`timescale 1ns/10ps

module xif_properties
  import xif_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      instr_valid_i,
  input logic      result_valid_o,
  input x_result_t result_o
);

  logic [2:0]      warm_q;
  logic            seen_q;
  logic [ID_W-1:0] last_id_q;
  int              assert_fails = 0;

  // Latency check waits until four cycles of history exist after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      warm_q    <= '0;
      seen_q    <= 1'b0;
      last_id_q <= '0;
    end else begin
      if (warm_q != 3'd4) begin
        warm_q <= warm_q + 3'd1;
      end
      if (result_valid_o) begin
        seen_q    <= 1'b1;
        last_id_q <= result_o.id;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    warm_q == 3'd4 |-> result_valid_o == $past(instr_valid_i, 4))
  else begin
    $error("result strobe differs from the instruction strobe four cycles earlier");
    assert_fails++;
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && result_o.exc |-> !result_o.we)
  else begin
    $error("exception result has its register write enable set");
    assert_fails++;
  end

  // Tags return in issue order and wrap at 16
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && seen_q |-> result_o.id == last_id_q + 4'd1)
  else begin
    $error("result id does not follow the previous result id");
    assert_fails++;
  end

endmodule : xif_properties

bind xif_subsystem xif_properties props_i (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .instr_valid_i (instr_valid_i),
  .result_valid_o(result_valid_o),
  .result_o      (result_o)
);

//--- sim/xif_subsystem_tb.sv
`timescale 1ns/10ps

module xif_subsystem_tb
  import xif_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int N_DIRECTED  = 29;
  localparam int N_RANDOM    = 160;
  localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM + 20) * CLK_PERIOD * 2;

  logic        clk_i;
  logic        arst_n_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] rs1_i;
  logic [31:0] rs2_i;
  logic        result_valid_o;
  x_result_t   result_o;
  logic        run_done;

  int pass_cnt;
  int err_cnt;
  int pending;
  int err_base;
  int total_err;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  xif_subsystem dut_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .result_valid_o(result_valid_o),
    .result_o      (result_o)
  );

  xif_checker chk_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .result_valid_i(result_valid_o),
    .result_i      (result_o),
    .run_done_i    (run_done),
    .pass_cnt_o    (pass_cnt),
    .err_cnt_o     (err_cnt),
    .pending_o     (pending)
  );

  // R-type layout, register fields unused by the coprocessor
  function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  // Extremes show up often so saturation gets exercised
  function automatic logic [31:0] pick_operand();
    case ($urandom_range(7))
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h7fff_ffff;
      3:       return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  function automatic logic [31:0] random_instr();
    logic [6:0] opc;
    logic [6:0] f7;
    opc = ($urandom_range(9) == 0) ? 7'b0110011 : CUSTOM0_OPCODE;
    f7  = ($urandom_range(9) == 0) ? 7'b0000001 : 7'b0000000;
    return encode_rtype(f7, 3'($urandom_range(7)), 5'($urandom), opc);
  endfunction

  task automatic send_word(input logic [31:0] instr, input logic [31:0] a,
                           input logic [31:0] b);
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    rs1_i         <= a;
    rs2_i         <= b;
    @(posedge clk_i);
  endtask

  task automatic send_op(input copro_op_e op, input logic [4:0] rd, input logic [31:0] a,
                         input logic [31:0] b);
    send_word(encode_rtype(7'd0, 3'(op), rd, CUSTOM0_OPCODE), a, b);
  endtask

  task automatic idle_cycles(input int n);
    instr_valid_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  // Wait until the checker holds nothing in flight, then report the test
  task automatic close_test(input string name);
    int waited;
    instr_valid_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (pending != 0 && waited < 10) begin
      @(negedge clk_i);
      waited++;
    end
    $display("Test %s: %0d mismatches", name, err_cnt - err_base);
    err_base = err_cnt;
    @(posedge clk_i);
  endtask

  initial begin
    void'($urandom(32'h840d_a0de));
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rs1_i         = '0;
    rs2_i         = '0;
    run_done      = 1'b0;
    err_base      = 0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    send_op(OP_ADDSAT, 5'd1, 32'h7fff_ffff, 32'h0000_0001);
    send_op(OP_ADDSAT, 5'd2, 32'h8000_0000, 32'hffff_ffff);
    send_op(OP_ADDSAT, 5'd3, 32'h0000_0005, 32'hffff_fffd);
    send_op(OP_MIN,    5'd4, 32'h0000_0009, 32'h0000_0009);
    send_op(OP_MIN,    5'd5, 32'h8000_0000, 32'h7fff_ffff);
    send_op(OP_MAX,    5'd6, 32'hffff_fffe, 32'hffff_fffe);
    send_op(OP_MAX,    5'd7, 32'hffff_fffe, 32'h0000_0003);
    send_op(OP_POPCNT, 5'd8, 32'h0000_0000, 32'h0);
    send_op(OP_POPCNT, 5'd9, 32'hffff_ffff, 32'h0);
    send_op(OP_POPCNT, 5'd10, 32'h0f0f_00f1, 32'h0);
    send_op(OP_CLZ,    5'd11, 32'h0000_0000, 32'h0);
    send_op(OP_CLZ,    5'd12, 32'hffff_ffff, 32'h0);
    send_op(OP_CLZ,    5'd13, 32'h0000_0001, 32'h0);
    send_op(OP_CLZ,    5'd14, 32'h0001_0000, 32'h0);
    close_test("arith");

    // Back to back so later words depend on accumulator updates in flight
    send_op(OP_MAC,    5'd1, 32'd3, 32'd4);
    send_op(OP_MAC,    5'd2, 32'd5, 32'd6);
    send_op(OP_MAC,    5'd3, 32'hffff_ffff, 32'd2);
    send_op(OP_MAC,    5'd4, 32'h0001_0000, 32'h0001_0003);
    send_op(OP_ACCCLR, 5'd5, 32'd0, 32'd0);
    send_op(OP_MAC,    5'd6, 32'd7, 32'd7);
    send_op(OP_ACCCLR, 5'd7, 32'd0, 32'd0);
    close_test("mac");

    send_op(OP_MAC, 5'd1, 32'd10, 32'd10);
    send_word(encode_rtype(7'd0, 3'd5, 5'd2, 7'b0101011), 32'd3, 32'd3);
    send_word(encode_rtype(7'd1, 3'd5, 5'd3, CUSTOM0_OPCODE), 32'd3, 32'd3);
    send_word(encode_rtype(7'd0, 3'd7, 5'd4, CUSTOM0_OPCODE), 32'd3, 32'd3);
    send_op(OP_ACCCLR, 5'd5, 32'd0, 32'd0);
    close_test("illegal");

    send_op(OP_ADDSAT, 5'd0, 32'd2, 32'd3);
    send_op(OP_MAX,    5'd0, 32'hffff_ff00, 32'd1);
    send_op(OP_POPCNT, 5'd0, 32'h0000_00ff, 32'd0);
    close_test("rd_zero");

    for (int i = 0; i < N_RANDOM; i++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycles($urandom_range(2, 1));
      end
      send_word(random_instr(), pick_operand(), pick_operand());
    end
    close_test("random");

    run_done <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    total_err = err_cnt + dut_i.props_i.assert_fails;
    $display("Done: %0d results matched, %0d failures", pass_cnt, total_err);
    if (total_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule : xif_subsystem_tb
